/* Makefile */
TOP = flowSteerTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir

/* all.f */
source/flowPkg.sv
source/apbIf.sv
source/flowRegSlice.sv
source/routeTable.sv
source/flowDemuxSelect.sv
source/flowSteer.sv
bench/flowSteer_chk.sv
bench/flowSteerTb.sv

/* bench/flowSteerTb.sv */
// Built for NumFlows of 4; routes are reprogrammed only while the pipeline is empty
`timescale 1ns/1ps
`default_nettype none

module flowSteerTb import flowPkg::*; ();

  localparam int NumFlows = 4;
  localparam int DestWidth = $clog2(NumFlows);
  localparam int Phase1Words = 32;
  localparam int RemapWords = 32;
  localparam int BurstWords = 16;
  localparam int RandomWords = 200;
  // Sixteen writes, sixteen reads and seven error-phase accesses take two cycles each
  localparam int ApbOps = 2 * NumEntries + 7;
  localparam int StimCycles =
    2 + Phase1Words + RemapWords + BurstWords + RandomWords + 2 * ApbOps;
  localparam int TimeoutCycles = 4 * StimCycles + 200;

  logic                    clk;
  logic                    arstN;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [ApbAddrWidth-1:0] paddr;
  logic [ApbDataWidth-1:0] pwdata;
  logic [ApbDataWidth-1:0] prdata;
  logic                    pslverr;
  logic                    inValid;
  logic                    inReady;
  wordT                    inWord;
  logic [NumFlows-1:0]     outValid;
  logic [NumFlows-1:0]     outReady = '1;
  wordT [NumFlows-1:0]     outWord;

  // Reference copy of the route table and the words still owed on each flow
  logic [DestWidth-1:0] model [NumEntries];
  wordT                 expQ [NumFlows][$];
  int                   dueQ [NumFlows][$];

  int          errors = 0;
  int          checks = 0;
  int          cycle = 0;
  bit          timed = 0;
  bit          randomReady = 0;
  int unsigned dataState = 32'h4992475a;
  int unsigned readyState = ~32'h4992475a;

  flowSteer #(.NumFlows(NumFlows)) dut0 (.*);

  // ----------------------------------------------------------
  // Clock, cycle count and timeout
  // ----------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Errors found");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  function automatic int unsigned lcgNext(input int unsigned s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int unsigned nextData();
    dataState = lcgNext(dataState);
    return dataState;
  endfunction

  function automatic wordT randomWord(input logic [TagWidth-1:0] tag);
    wordT        w;
    int unsigned r;
    r = nextData();
    w.tag = tag;
    w.payload = r[31:4];
    return w;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int i = 0; i < NumFlows; i++) begin
      n += expQ[i].size();
    end
    return n;
  endfunction

  task automatic compareValue(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Holds the word until the edge that takes it, then returns 1 ns later
  task automatic sendWord(input wordT w);
    inValid = 1'b1;
    inWord = w;
    @(negedge clk);
    while (!inReady) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  // Waits until every sent word has left the last stage
  // The queues only change at the falling edge, so the rising edge sees them settled
  task automatic drain();
    @(posedge clk);
    while (pending() != 0) @(posedge clk);
    #1;
  endtask

  // Setup phase then access phase with the response sampled mid access phase
  task automatic apbAccess(input logic write, input logic [ApbAddrWidth-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // Only offsets below 64 and destinations below NumFlows are accepted
  task automatic writeEntry(input logic [ApbAddrWidth-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    bit          ok;
    ok = (addr < 8'd64) && (data < 32'(NumFlows));
    apbAccess(1'b1, addr, data, rdata, err);
    compareValue(32'(err), 32'(!ok), $sformatf("pslverr on write to %h", addr));
    if (ok) model[addr[5:2]] = DestWidth'(data);
  endtask

  task automatic readEntry(input logic [ApbAddrWidth-1:0] addr);
    logic [31:0] rdata;
    logic        err;
    apbAccess(1'b0, addr, '0, rdata, err);
    compareValue(32'(err), 32'(addr >= 8'd64), $sformatf("pslverr on read of %h", addr));
    if (addr < 8'd64) compareValue(rdata, 32'(model[addr[5:2]]), "route entry");
  endtask

  // ----------------------------------------------------------
  // Monitor
  // ----------------------------------------------------------

  // Transfers happen on the next rising edge, so values here are settled
  always @(negedge clk) begin : monitor
    int   dest;
    int   due;
    wordT expWord;
    if (arstN) begin
      // With every output ready the input side must take one word per cycle
      if (timed && inValid) begin
        compareValue(32'(inReady), 32'd1, "inReady during burst");
      end
      if (inValid && inReady) begin
        dest = int'(model[inWord.tag]);
        expQ[dest].push_back(inWord);
        // Two edges later the word leaves stage 2
        dueQ[dest].push_back(cycle + 2);
      end
      for (int i = 0; i < NumFlows; i++) begin
        if (outValid[i] && outReady[i]) begin
          assert (expQ[i].size() != 0) else begin
            errors++;
            $display("Flow %0d delivered a word when none was owed", i);
          end
          if (expQ[i].size() != 0) begin
            expWord = expQ[i].pop_front();
            due = dueQ[i].pop_front();
            compareValue(outWord[i], expWord, $sformatf("flow %0d word", i));
            if (timed) compareValue(cycle, due, $sformatf("flow %0d arrival cycle", i));
          end
        end
      end
    end
  end

  // Random back-pressure gives each flow a 3 in 4 chance of ready
  always @(posedge clk) begin : readyDriver
    logic [NumFlows-1:0] next;
    #1;
    next = '1;
    if (randomReady) begin
      for (int i = 0; i < NumFlows; i++) begin
        readyState = lcgNext(readyState);
        next[i] = readyState[31:30] != 2'b00;
      end
    end
    outReady = next;
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------

  initial begin
    int unsigned r;
    arstN = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    inValid = 1'b0;
    inWord = '0;
    for (int i = 0; i < NumEntries; i++) begin
      model[i] = DestWidth'(i % NumFlows);
    end
    repeat (2) @(posedge clk);
    #1;
    arstN = 1'b1;

    // Every tag in turn through the reset map
    for (int i = 0; i < Phase1Words; i++) begin
      sendWord(randomWord(TagWidth'(i)));
    end
    inValid = 1'b0;
    drain();

    // Remap all tags, read the table back, then route through the new map
    for (int i = 0; i < NumEntries; i++) begin
      r = nextData();
      writeEntry(ApbAddrWidth'(4 * i), 32'(r % NumFlows));
    end
    for (int i = 0; i < NumEntries; i++) begin
      readEntry(ApbAddrWidth'(4 * i));
    end
    for (int i = 0; i < RemapWords; i++) begin
      r = nextData();
      sendWord(randomWord(r[31:28]));
    end
    inValid = 1'b0;
    drain();

    // Bad offset and bad destination leave the table alone
    // Known entries first, so a write that slipped through would show on read-back
    writeEntry(8'h00, 32'd0);
    writeEntry(8'h0c, 32'(NumFlows - 1));
    writeEntry(8'h40, 32'd1);
    writeEntry(8'h0c, 32'(NumFlows));
    readEntry(8'h00);
    readEntry(8'h0c);
    readEntry(8'h44);

    // Back-to-back burst with every output ready
    timed = 1'b1;
    for (int i = 0; i < BurstWords; i++) begin
      r = nextData();
      sendWord(randomWord(r[31:28]));
    end
    inValid = 1'b0;
    drain();
    timed = 1'b0;

    // Random back-pressure
    @(negedge clk);
    randomReady = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < RandomWords; i++) begin
      r = nextData();
      sendWord(randomWord(r[31:28]));
    end
    inValid = 1'b0;
    @(negedge clk);
    randomReady = 1'b0;
    drain();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/flowSteer_chk.sv */
// Bound into flowSteer; assumes the zero-wait APB and a select held with the data in stage 2
`timescale 1ns/1ps
`default_nettype none

module flowSteer_chk import flowPkg::*; #(
  parameter int NumFlows = 4
) (
  input logic                clk,
  input logic                arstN,
  input logic                inReady,
  input logic [NumFlows-1:0] outValid,
  input logic [NumFlows-1:0] outReady,
  input wordT [NumFlows-1:0] outWord,
  input logic                psel,
  input logic                penable,
  input logic                pready
);

  // ----------------------------------------------------------
  // Output streams
  // ----------------------------------------------------------

  // A word goes to one flow at most
  oneFlow: assert property (@(posedge clk) disable iff (!arstN) $onehot0(outValid))
    else $error("More than one outValid bit is high");

  // A stalled flow keeps offering the same word
  for (genvar i = 0; i < NumFlows; i++) begin : holdCheck
    stallHold: assert property (@(posedge clk) disable iff (!arstN)
      outValid[i] && !outReady[i] |=> outValid[i] && $stable(outWord[i]))
      else $error("Flow %0d dropped or changed its word while stalled", i);
  end

  // ----------------------------------------------------------
  // Reset and APB
  // ----------------------------------------------------------

  // Both stages come out of reset empty
  readyAfterReset: assert property (@(posedge clk) $rose(arstN) |-> inReady)
    else $error("inReady is low right after reset");

  noWait: assert property (@(posedge clk) disable iff (!arstN) psel && penable |-> pready)
    else $error("APB access phase saw pready low");

endmodule

bind flowSteer flowSteer_chk #(.NumFlows(NumFlows)) chk0 (
  .clk     (clk),
  .arstN   (arstN),
  .inReady (inReady),
  .outValid(outValid),
  .outReady(outReady),
  .outWord (outWord),
  .psel    (psel),
  .penable (penable),
  .pready  (apbBus.pready)
);

`default_nettype wire

/* source/apbIf.sv */
// APB bus without protection or strobes; the completer may tie pready high
`timescale 1ns/1ps
`default_nettype none

interface apbIf import flowPkg::*; ();

  // Requester-driven control and write data
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [ApbAddrWidth-1:0] paddr;
  logic [ApbDataWidth-1:0] pwdata;

  // Completer-driven response
  logic [ApbDataWidth-1:0] prdata;
  logic                    pready;
  logic                    pslverr;

  // The side that starts transfers
  modport requester(
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  // The side that answers them
  modport completer(
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

`default_nettype wire

/* source/flowDemuxSelect.sv */
// Combinational demux; pop side is stable only if select is held with the data upstream
`timescale 1ns/1ps
`default_nettype none

module flowDemuxSelect import flowPkg::*; #(
  // Number of pop ports, at least 2
  parameter int NumFlows = 4,
  localparam int SelectWidth = $clog2(NumFlows)
) (
  // Binary index of the pop port, must stay below NumFlows
  input  logic [SelectWidth-1:0]   select,

  // Push side
  input  logic                     pushValid,
  output logic                     pushReady,
  input  wordT                     pushWord,

  // Pop side, one element per flow
  output logic [NumFlows-1:0]      popValid,
  input  logic [NumFlows-1:0]      popReady,
  output wordT [NumFlows-1:0]      popWord
);

  // ----------------------------------------------------------
  // Steering
  // ----------------------------------------------------------

  // Only the selected flow can stall the push side
  assign pushReady = popReady[select];

  // The ternary keeps all pop valids low while push is idle
  assign popValid = pushValid ? (NumFlows'(1) << select) : '0;

  // Each pop port sees the same word
  // A pop word only counts where its valid is high
  always_comb begin
    for (int i = 0; i < NumFlows; i++) begin
      popWord[i] = pushWord;
    end
  end

endmodule

`default_nettype wire

/* source/flowPkg.sv */
// Fixed 4-bit tag and 28-bit payload in one 32-bit APB word; route entries sit on 4-byte strides
`default_nettype none

package flowPkg;

  // ----------------------------------------------------------
  // Word layout
  // ----------------------------------------------------------

  // Routing tag width, which sets the number of route entries
  localparam int TagWidth = 4;
  // Data bits that travel with the tag
  localparam int PayloadWidth = 28;
  localparam int NumEntries = 2 ** TagWidth;

  // Tag sits in the upper bits, so a word reads naturally on the APB
  typedef struct packed {
    logic [TagWidth-1:0]     tag;
    logic [PayloadWidth-1:0] payload;
  } wordT;

  // ----------------------------------------------------------
  // APB register map
  // ----------------------------------------------------------

  localparam int ApbAddrWidth = 8;
  // One data word is exactly one stream word wide
  localparam int ApbDataWidth = $bits(wordT);

  // Entry i lives at byte offset 4*i, anything past the last entry is an error
  function automatic logic offsetInRange(input logic [ApbAddrWidth-1:0] addr);
    return addr < ApbAddrWidth'(NumEntries * 4);
  endfunction

  // The two byte-lane bits are ignored when picking an entry
  function automatic logic [TagWidth-1:0] entryIndex(input logic [ApbAddrWidth-1:0] addr);
    return addr[TagWidth+1:2];
  endfunction

endpackage

`default_nettype wire

/* source/flowRegSlice.sv */
// Single full-throughput register stage; payload has no reset and is valid only with outValid
`timescale 1ns/1ps
`default_nettype none

module flowRegSlice #(
  // Any packed type, a word or a word plus its route
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    arstN,

  // Upstream side
  input  logic    inValid,
  output logic    inReady,
  input  payloadT inData,

  // Downstream side
  output logic    outValid,
  input  logic    outReady,
  output payloadT outData
);

  // ----------------------------------------------------------
  // Flow control
  // ----------------------------------------------------------

  // Accept when empty, or when the held word leaves this same edge
  // This keeps one word per cycle with no bubble
  assign inReady = !outValid || outReady;

  // Valid follows the input whenever the slot is free to change
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;
    end
  end

  // ----------------------------------------------------------
  // Payload register
  // ----------------------------------------------------------

  // Capture only on a real transfer
  // A stalled stage therefore keeps its data steady
  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      outData <= inData;
    end
  end

endmodule

`default_nettype wire

/* source/flowSteer.sv */
// Head-of-line routing, no reordering or per-flow buffering; reprogram routes only when idle
`timescale 1ns/1ps
`default_nettype none

module flowSteer import flowPkg::*; #(
  // Number of output flows, at least 2
  parameter int NumFlows = 4,
  localparam int DestWidth = $clog2(NumFlows)
) (
  input  logic                    clk,
  input  logic                    arstN,

  // APB programming port, always ready
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [ApbAddrWidth-1:0] paddr,
  input  logic [ApbDataWidth-1:0] pwdata,
  output logic [ApbDataWidth-1:0] prdata,
  output logic                    pslverr,

  // Input stream
  input  logic                    inValid,
  output logic                    inReady,
  input  wordT                    inWord,

  // Output streams, one per flow
  output logic [NumFlows-1:0]     outValid,
  input  logic [NumFlows-1:0]     outReady,
  output wordT [NumFlows-1:0]     outWord
);

  // Word plus its destination, carried through stage 2 together
  typedef struct packed {
    wordT                 word;
    logic [DestWidth-1:0] dest;
  } routedT;

  // ----------------------------------------------------------
  // APB bus
  // ----------------------------------------------------------

  apbIf apbBus ();

  assign apbBus.psel    = psel;
  assign apbBus.penable = penable;
  assign apbBus.pwrite  = pwrite;
  assign apbBus.paddr   = paddr;
  assign apbBus.pwdata  = pwdata;
  assign prdata         = apbBus.prdata;
  assign pslverr        = apbBus.pslverr;

  // ----------------------------------------------------------
  // Pipeline
  // ----------------------------------------------------------

  logic                 s1Valid;
  logic                 s1Ready;
  wordT                 s1Word;
  logic [DestWidth-1:0] lookupDest;
  routedT               s2In;
  logic                 s2Valid;
  logic                 s2Ready;
  routedT               s2Out;

  flowRegSlice #(.payloadT(wordT)) stage1 (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (inValid),
    .inReady (inReady),
    .inData  (inWord),
    .outValid(s1Valid),
    .outReady(s1Ready),
    .outData (s1Word)
  );

  // The route is looked up while the word waits in stage 1
  routeTable #(.NumFlows(NumFlows)) routes (
    .clk       (clk),
    .arstN     (arstN),
    .apb       (apbBus.completer),
    .lookupTag (s1Word.tag),
    .lookupDest(lookupDest)
  );

  assign s2In = '{word: s1Word, dest: lookupDest};

  // Holding the select here keeps the demux outputs stable under stall
  flowRegSlice #(.payloadT(routedT)) stage2 (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (s1Valid),
    .inReady (s1Ready),
    .inData  (s2In),
    .outValid(s2Valid),
    .outReady(s2Ready),
    .outData (s2Out)
  );

  flowDemuxSelect #(.NumFlows(NumFlows)) demux (
    .select   (s2Out.dest),
    .pushValid(s2Valid),
    .pushReady(s2Ready),
    .pushWord (s2Out.word),
    .popValid (outValid),
    .popReady (outReady),
    .popWord  (outWord)
  );

endmodule

`default_nettype wire

/* source/routeTable.sv */
// Sixteen APB-writable destinations, no wait states; bad offset or destination gives pslverr
`timescale 1ns/1ps
`default_nettype none

module routeTable import flowPkg::*; #(
  // Number of output flows, at least 2
  parameter int NumFlows = 4,
  localparam int DestWidth = $clog2(NumFlows)
) (
  input  logic                 clk,
  input  logic                 arstN,

  // Register access from the processor
  apbIf.completer              apb,

  // Lookup port used by the pipeline, zero latency
  input  logic [TagWidth-1:0]  lookupTag,
  output logic [DestWidth-1:0] lookupDest
);

  // ----------------------------------------------------------
  // Access decode
  // ----------------------------------------------------------

  logic                 access;
  logic                 offsetOk;
  logic                 valueOk;
  logic                 writeOk;
  logic [TagWidth-1:0]  regIndex;
  logic [DestWidth-1:0] destTable [NumEntries];

  // Every transfer completes in its access phase
  assign access = apb.psel && apb.penable;

  assign offsetOk = offsetInRange(apb.paddr);
  assign regIndex = entryIndex(apb.paddr);

  // The whole write word is checked, not only the low bits kept
  assign valueOk = apb.pwdata < ApbDataWidth'(NumFlows);

  assign writeOk = access && apb.pwrite && offsetOk && valueOk;

  // ----------------------------------------------------------
  // Response
  // ----------------------------------------------------------

  assign apb.pready = 1'b1;

  // A write error leaves the table untouched
  assign apb.pslverr = access && (!offsetOk || (apb.pwrite && !valueOk));

  // Reads return the entry zero-extended, out-of-range reads return zero
  assign apb.prdata = offsetOk ? ApbDataWidth'(destTable[regIndex]) : '0;

  // ----------------------------------------------------------
  // Table storage
  // ----------------------------------------------------------

  // After reset, tag i goes to flow i mod NumFlows
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < NumEntries; i++) begin
        destTable[i] <= DestWidth'(i % NumFlows);
      end
    end else if (writeOk) begin
      destTable[regIndex] <= apb.pwdata[DestWidth-1:0];
    end
  end

  // The tag indexes the table directly
  assign lookupDest = destTable[lookupTag];

endmodule

`default_nettype wire
